/* files.f */
+incdir+hdl
hdl/domPkg.sv
hdl/domMulGf2.sv
hdl/domSqScMulGf2.sv
hdl/domInvGf4.sv
hdl/creditBuffer.sv
hdl/maskedInvTop.sv
test/tbMaskedInv.sv

/* hdl/creditBuffer.sv */
`include "gfInv_macros.svh"

module creditBuffer (
    input  logic         ClkxCI,
    input  logic         rstN,
    input  logic         inValid,
    input  domPkg::nib_t inShares,
    input  logic         creditIn,
    output logic         outValid,
    output domPkg::nib_t outShares,
    output logic         creditOut
);
    import domPkg::*;

    localparam int D  = `OUT_DEPTH;
    localparam int PW = (D > 1) ? $clog2(D) : 1;

    nib_t mem [D];

    logic [PW-1:0] wrPtr;
    logic [PW-1:0] rdPtr;
    logic [PW-1:0] wrNext;
    logic [PW-1:0] rdNext;

    // Slots granted by the consumer and not yet used
    logic [`CRED_W-1:0] credits;

    bufState_t state;

    logic enq;
    logic deq;

    assign enq = inValid && (state != FULL);
    assign deq = (credits != '0) && (state != EMPTY);

    // Pointers wrap at D, which need not be a power of two
    assign wrNext = (wrPtr == PW'(D - 1)) ? '0 : wrPtr + 1'b1;
    assign rdNext = (rdPtr == PW'(D - 1)) ? '0 : rdPtr + 1'b1;

    always_ff @(posedge ClkxCI) begin
        if (enq) begin
            mem[wrPtr] <= inShares;
        end
    end

    always_ff @(posedge ClkxCI or negedge rstN) begin
        if (!rstN) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            credits <= '0;
            state   <= EMPTY;
        end else begin
            if (enq) begin
                wrPtr <= wrNext;
            end
            if (deq) begin
                rdPtr <= rdNext;
            end

            if (creditIn && !deq) begin
                credits <= credits + 1'b1;
            end else if (!creditIn && deq) begin
                credits <= credits - 1'b1;
            end

            // Equal pointers are resolved by the state
            case ({enq, deq})
                2'b10: state <= (wrNext == rdPtr) ? FULL : PARTIAL;
                2'b01: state <= (rdNext == wrPtr) ? EMPTY : PARTIAL;
                default: state <= state;
            endcase
        end
    end

    assign outValid  = deq;
    assign outShares = mem[rdPtr];
    // Every slot freed goes straight back upstream
    assign creditOut = deq;

    // Upstream credit discipline keeps a full buffer idle
    aNoEnqFull : assert property (@(posedge ClkxCI) disable iff (!rstN)
        !(inValid && state == FULL))
        else $error("input accepted while the output buffer is full");

    aCreditNoWrap : assert property (@(posedge ClkxCI) disable iff (!rstN)
        $past(rstN) |-> int'(credits) ==
            int'($past(credits)) + int'($past(creditIn)) - int'($past(deq)))
        else $error("downstream credit counter wrapped");

endmodule

/* hdl/domInvGf4.sv */
`include "gfInv_macros.svh"

module domInvGf4 (
    input  logic          ClkxCI,
    input  logic          rstN,
    input  logic          inValid,
    input  domPkg::nib_t  x,
    input  domPkg::zRnd_t zMul1,
    input  domPkg::zRnd_t zMul2,
    input  domPkg::zRnd_t zMul3,
    output logic          invValid,
    output domPkg::nib_t  q
);
    import domPkg::*;

    localparam int S = `SHARES;

    // High and low GF(2^2) halves of every share
    dib_t aSh;
    dib_t bSh;
    // Stage 1 copies, aligned with E
    dib_t aQ;
    dib_t bQ;
    zRnd_t z2Q;
    zRnd_t z3Q;

    dib_t eSh;
    dib_t aeSh;
    dib_t beSh;

    logic [1:0] validPipe;

    for (genvar i = 0; i < S; i++) begin : gSplit
        assign aSh[2*i +: 2] = x[4*i + 2 +: 2];
        assign bSh[2*i +: 2] = x[4*i +: 2];
    end

    // Stage 1: E = (nu*(A+B)^2 + A*B)^-1
    domSqScMulGf2 uNorm (
        .ClkxCI (ClkxCI),
        .rstN   (rstN),
        .x      (aSh),
        .y      (bSh),
        .z      (zMul1),
        .e      (eSh)
    );

    // Halves and stage 2 masks wait one cycle for E
    always_ff @(posedge ClkxCI) begin
        aQ  <= aSh;
        bQ  <= bSh;
        z2Q <= zMul2;
        z3Q <= zMul3;
    end

    // Stage 2: both products side by side
    domMulGf2 uMulAE (
        .ClkxCI (ClkxCI),
        .rstN   (rstN),
        .x      (aQ),
        .y      (eSh),
        .z      (z2Q),
        .q      (aeSh)
    );

    domMulGf2 uMulBE (
        .ClkxCI (ClkxCI),
        .rstN   (rstN),
        .x      (bQ),
        .y      (eSh),
        .z      (z3Q),
        .q      (beSh)
    );

    // Halves swap on the way out
    for (genvar i = 0; i < S; i++) begin : gJoin
        assign q[4*i +: 4] = {beSh[2*i +: 2], aeSh[2*i +: 2]};
    end

    always_ff @(posedge ClkxCI or negedge rstN) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[0], inValid};
        end
    end

    assign invValid = validPipe[1];

    // Data path latency and valid marker must agree
    aValidDelay : assert property (@(posedge ClkxCI) disable iff (!rstN)
        $past(rstN) && $past(rstN, 2) |-> invValid == $past(inValid, 2))
        else $error("invValid is not inValid delayed by two cycles");

endmodule

/* hdl/domMulGf2.sv */
`include "gfInv_macros.svh"

module domMulGf2 (
    input  logic          ClkxCI,
    input  logic          rstN,
    input  domPkg::dib_t  x,
    input  domPkg::dib_t  y,
    input  domPkg::zRnd_t z,
    output domPkg::dib_t  q
);
    import domPkg::*;

    localparam int S = `SHARES;

    // All share products, first index is the domain of x
    gf2_t termD [S][S];
    gf2_t termQ [S][S];

    // Normal-basis product in GF(2^2)
    function automatic gf2_t mulGf2(gf2_t a, gf2_t b);
        logic s;
        s = (a[1] ^ a[0]) & (b[1] ^ b[0]);
        return {(a[1] & b[1]) ^ s, (a[0] & b[0]) ^ s};
    endfunction

    // Position of the mask for pair lo<hi in z
    function automatic int pairIdx(int lo, int hi);
        return lo * `SHARES - (lo * (lo + 1)) / 2 + (hi - lo - 1);
    endfunction

    for (genvar i = 0; i < S; i++) begin : gDomI
        for (genvar j = 0; j < S; j++) begin : gDomJ
            if (i == j) begin : gInner
                // Inner-domain term needs no fresh mask
                assign termD[i][j] = mulGf2(x[2*i +: 2], y[2*j +: 2]);
            end else begin : gCross
                // Both domains of a pair share the same mask
                localparam int P = (i < j) ? pairIdx(i, j) : pairIdx(j, i);
                assign termD[i][j] = mulGf2(x[2*i +: 2], y[2*j +: 2]) ^ z[2*P +: 2];
            end
        end
    end

    // Resharing register, stops glitches crossing domains
    always_ff @(posedge ClkxCI or negedge rstN) begin
        if (!rstN) begin
            termQ <= '{default: '0};
        end else begin
            termQ <= termD;
        end
    end

    // Integration: each domain folds its own row
    always_comb begin
        q = '0;
        for (int i = 0; i < S; i++) begin
            for (int j = 0; j < S; j++) begin
                q[2*i +: 2] = q[2*i +: 2] ^ termQ[i][j];
            end
        end
    end

endmodule

/* hdl/domPkg.sv */
`include "gfInv_macros.svh"

package domPkg;

    // One GF(2^2) element in normal basis {w, w^2}
    // Bit 1 is the w coefficient, bit 0 the w^2 coefficient
    typedef logic [1:0] gf2_t;

    // Shared GF(2^4) value, share i in nibble i
    typedef logic [4*`SHARES-1:0] nib_t;

    // Shared GF(2^2) value, share i in bits 2i+1:2i
    typedef logic [2*`SHARES-1:0] dib_t;

    // Resharing masks of one DOM multiplier
    // One 2-bit mask per unordered share pair i<j
    typedef logic [`SHARES*(`SHARES-1)-1:0] zRnd_t;

    // Occupancy of the output FIFO
    typedef enum logic [1:0] {
        EMPTY,
        PARTIAL,
        FULL
    } bufState_t;

endpackage

/* hdl/domSqScMulGf2.sv */
`include "gfInv_macros.svh"

module domSqScMulGf2 (
    input  logic          ClkxCI,
    input  logic          rstN,
    input  domPkg::dib_t  x,
    input  domPkg::dib_t  y,
    input  domPkg::zRnd_t z,
    output domPkg::dib_t  e
);
    import domPkg::*;

    localparam int S = `SHARES;

    dib_t prod;
    gf2_t linD [S];
    gf2_t linQ [S];

    // Squaring in normal basis swaps the coefficients
    function automatic gf2_t sqGf2(gf2_t a);
        return {a[0], a[1]};
    endfunction

    // Scaling by nu = w
    function automatic gf2_t sclNu(gf2_t a);
        return {a[0], a[1] ^ a[0]};
    endfunction

    // Masked x*y, valid one cycle later
    domMulGf2 uMulXY (
        .ClkxCI (ClkxCI),
        .rstN   (rstN),
        .x      (x),
        .y      (y),
        .z      (z),
        .q      (prod)
    );

    // Linear part is share-wise, no randomness needed
    for (genvar i = 0; i < S; i++) begin : gLin
        assign linD[i] = sclNu(sqGf2(x[2*i +: 2] ^ y[2*i +: 2]));
    end

    // Keep the linear part in step with the multiplier
    always_ff @(posedge ClkxCI or negedge rstN) begin
        if (!rstN) begin
            linQ <= '{default: '0};
        end else begin
            linQ <= linD;
        end
    end

    // Norm per share, then square it to get its inverse
    for (genvar i = 0; i < S; i++) begin : gNorm
        gf2_t norm;
        assign norm = linQ[i] ^ prod[2*i +: 2];
        assign e[2*i +: 2] = sqGf2(norm);
    end

endmodule

/* hdl/gfInv_macros.svh */
`ifndef GF_INV_MACROS_SVH
`define GF_INV_MACROS_SVH

// Number of shares per masked value
// 2 gives first-order protection, 3 gives second order
`define SHARES 2

// Output buffer entries, also the upstream credit pool
`define OUT_DEPTH 4

// Credit counters must be able to hold a full pool
`define CRED_W ($clog2(`OUT_DEPTH + 1))

`endif

/* hdl/maskedInvTop.sv */
module maskedInvTop (
    input  logic          ClkxCI,
    input  logic          rstN,
    input  logic          inValid,
    input  domPkg::nib_t  inShares,
    input  domPkg::zRnd_t zMul1,
    input  domPkg::zRnd_t zMul2,
    input  domPkg::zRnd_t zMul3,
    input  logic          creditIn,
    output logic          outValid,
    output domPkg::nib_t  outShares,
    output logic          creditOut
);

    // Inverter result, two cycles behind the input
    logic         invValid;
    domPkg::nib_t invShares;

    domInvGf4 uInv (
        .ClkxCI   (ClkxCI),
        .rstN     (rstN),
        .inValid  (inValid),
        .x        (inShares),
        .zMul1    (zMul1),
        .zMul2    (zMul2),
        .zMul3    (zMul3),
        .invValid (invValid),
        .q        (invShares)
    );

    // Credits bound the items in flight, so the pipeline never stalls
    creditBuffer uBuf (
        .ClkxCI    (ClkxCI),
        .rstN      (rstN),
        .inValid   (invValid),
        .inShares  (invShares),
        .creditIn  (creditIn),
        .outValid  (outValid),
        .outShares (outShares),
        .creditOut (creditOut)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the masked inverter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tbMaskedInv -f files.f -o simMaskedInv

simOut=$(./obj_dir/simMaskedInv)
echo "$simOut"

# The testbench prints the pass line only when every check held
if echo "$simOut" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

/* test/tbMaskedInv.sv */
`include "gfInv_macros.svh"

module tbMaskedInv;
    timeunit 1ns;
    timeprecision 1ps;

    import domPkg::*;

    localparam int NUM_ITEMS   = 8 + 16 + 64 + 32;
    localparam int CYCLE_LIMIT = 40 * NUM_ITEMS + 200;

    // Downstream consumer behavior
    localparam int GRANT  = 0;
    localparam int HOLD   = 1;
    localparam int RANDOM = 2;

    logic  ClkxCI;
    logic  rstN;
    logic  inValid;
    nib_t  inShares;
    zRnd_t zMul1;
    zRnd_t zMul2;
    zRnd_t zMul3;
    logic  creditIn;
    logic  outValid;
    nib_t  outShares;
    logic  creditOut;

    int seed = 32'hb861;
    int errCount = 0;
    int cycleCount = 0;
    int creditMode = HOLD;

    // Upstream and downstream credit bookkeeping
    int sentTotal = 0;
    int returnedTotal = 0;
    int dnGranted = 0;
    int dnConsumed = 0;

    int outTotal = 0;
    int streamCount = 0;
    int lastStreamCycle = 0;

    // Items waiting for an upstream credit
    logic [3:0] pendNib [$];
    logic [3:0] pendExp [$];
    string      pendName [$];
    // Items in flight in send order
    logic [3:0] expQ [$];
    string      nameQ [$];
    // Unmasked results of the first involution pass
    logic [3:0] fbQ [$];

    maskedInvTop u_dut (
        .ClkxCI    (ClkxCI),
        .rstN      (rstN),
        .inValid   (inValid),
        .inShares  (inShares),
        .zMul1     (zMul1),
        .zMul2     (zMul2),
        .zMul3     (zMul3),
        .creditIn  (creditIn),
        .outValid  (outValid),
        .outShares (outShares),
        .creditOut (creditOut)
    );

    // Discrete log to the base w where 1 = w + w^2
    function automatic int logOf(logic [1:0] a);
        case (a)
            2'b11:   return 0;
            2'b10:   return 1;
            default: return 2;
        endcase
    endfunction

    function automatic logic [1:0] expOf(int k);
        case (k)
            0:       return 2'b11;
            1:       return 2'b10;
            default: return 2'b01;
        endcase
    endfunction

    function automatic logic [1:0] mulSubfield(logic [1:0] a, logic [1:0] b);
        if (a == 2'b00 || b == 2'b00) begin
            return 2'b00;
        end
        return expOf((logOf(a) + logOf(b)) % 3);
    endfunction

    // Expected inverse of an unmasked nibble with high half A and low half B
    function automatic logic [3:0] invGf4(logic [3:0] v);
        logic [1:0] a;
        logic [1:0] b;
        logic [1:0] s;
        logic [1:0] d;
        logic [1:0] e;
        a = v[3:2];
        b = v[1:0];
        s = mulSubfield(a ^ b, a ^ b);
        // Norm with nu = w
        d = mulSubfield(s, 2'b10) ^ mulSubfield(a, b);
        e = mulSubfield(d, d);
        return {mulSubfield(b, e), mulSubfield(a, e)};
    endfunction

    function automatic logic [3:0] unmask(nib_t v);
        logic [3:0] acc;
        acc = '0;
        for (int i = 0; i < `SHARES; i++) begin
            acc = acc ^ v[4*i +: 4];
        end
        return acc;
    endfunction

    task automatic flagFault(input string msg);
        $display("Protocol fault at cycle %0d: %s", cycleCount, msg);
        errCount++;
    endtask

    task automatic flagMismatch(input string name, input int expected, input int actual);
        $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        errCount++;
    endtask

    task automatic queueItem(input logic [3:0] secret, input logic [3:0] expected,
                             input string name);
        pendNib.push_back(secret);
        pendExp.push_back(expected);
        pendName.push_back(name);
    endtask

    // Fresh sharing and fresh masks for every item
    task automatic sendItem();
        logic [3:0] acc;
        logic [3:0] share;
        nib_t shares;
        acc = pendNib.pop_front();
        shares = '0;
        for (int i = 0; i < `SHARES - 1; i++) begin
            share = 4'($random(seed));
            shares[4*i +: 4] = share;
            acc = acc ^ share;
        end
        shares[4*(`SHARES-1) +: 4] = acc;
        inValid  <= 1'b1;
        inShares <= shares;
        zMul1    <= zRnd_t'($random(seed));
        zMul2    <= zRnd_t'($random(seed));
        zMul3    <= zRnd_t'($random(seed));
        expQ.push_back(pendExp.pop_front());
        nameQ.push_back(pendName.pop_front());
        sentTotal++;
    endtask

    task automatic drainAll();
        while (pendNib.size() != 0 || expQ.size() != 0) begin
            @(negedge ClkxCI);
        end
    endtask

    initial begin
        ClkxCI = 1'b0;
        forever begin
            #10;
            ClkxCI = ~ClkxCI;
        end
    end

    initial begin
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge ClkxCI);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("%0d items checked, %0d errors", outTotal, errCount);
        $display("STATUS: FAIL");
        $finish;
    end

    // Producer sends only while it holds an upstream credit
    initial begin
        inValid  = 1'b0;
        inShares = '0;
        zMul1    = '0;
        zMul2    = '0;
        zMul3    = '0;
        forever begin
            @(posedge ClkxCI);
            if (rstN && pendNib.size() != 0 && sentTotal - returnedTotal < `OUT_DEPTH) begin
                sendItem();
            end else begin
                inValid <= 1'b0;
            end
        end
    end

    // Consumer with OUT_DEPTH slots of its own
    initial begin
        logic grant;
        creditIn = 1'b0;
        forever begin
            @(posedge ClkxCI);
            grant = 1'b0;
            if (rstN && dnGranted - dnConsumed < `OUT_DEPTH) begin
                if (creditMode == GRANT) begin
                    grant = 1'b1;
                end else if (creditMode == RANDOM) begin
                    grant = (($random(seed) & 3) != 0);
                end
            end
            creditIn <= grant;
            if (grant) begin
                dnGranted++;
            end
        end
    end

    // Scoreboard samples on the falling edge
    initial begin
        logic [3:0] actual;
        logic [3:0] expected;
        string name;
        forever begin
            @(negedge ClkxCI);
            if (rstN && creditOut) begin
                if (returnedTotal >= sentTotal) begin
                    flagFault("creditOut pulsed with no item outstanding upstream");
                end
                returnedTotal++;
            end
            if (rstN && outValid) begin
                actual = unmask(outShares);
                if (dnGranted <= dnConsumed) begin
                    flagFault("outValid without a downstream credit");
                end
                dnConsumed++;
                outTotal++;
                if (expQ.size() == 0) begin
                    flagFault("outValid with no item outstanding");
                end else begin
                    expected = expQ.pop_front();
                    name = nameQ.pop_front();
                    if (actual !== expected) begin
                        flagMismatch(name, int'(expected), int'(actual));
                    end
                    if (name == "involution-1") begin
                        fbQ.push_back(actual);
                    end
                    if (name == "streaming") begin
                        if (streamCount > 0 && cycleCount != lastStreamCycle + 1) begin
                            flagFault("streaming outputs are not on consecutive cycles");
                        end
                        lastStreamCycle = cycleCount;
                        streamCount++;
                    end
                end
            end
        end
    end

    initial begin
        logic [3:0] v;
        logic [3:0] orig [$];
        rstN = 1'b0;
        repeat (10) @(posedge ClkxCI);
        rstN <= 1'b1;

        // Nothing may leave the DUT while idle after reset
        repeat (20) begin
            @(negedge ClkxCI);
            if (outValid || creditOut) begin
                flagFault("outValid or creditOut active after reset with no traffic");
            end
        end

        // Back-pressure with no downstream credit granted yet
        for (int i = 0; i < 8; i++) begin
            v = 4'($random(seed));
            queueItem(v, invGf4(v), "backpressure");
        end
        while (sentTotal < `OUT_DEPTH) begin
            @(negedge ClkxCI);
        end
        repeat (12) @(negedge ClkxCI);
        if (sentTotal != `OUT_DEPTH) begin
            flagMismatch("backpressure accepted items", `OUT_DEPTH, sentTotal);
        end
        if (returnedTotal != 0) begin
            flagMismatch("backpressure creditOut pulses", 0, returnedTotal);
        end
        if (outTotal != 0) begin
            flagMismatch("backpressure outputs", 0, outTotal);
        end
        creditMode = GRANT;
        drainAll();

        // Streaming with the consumer pool full
        while (dnGranted - dnConsumed < `OUT_DEPTH) begin
            @(negedge ClkxCI);
        end
        for (int i = 0; i < 16; i++) begin
            queueItem(4'(i), invGf4(4'(i)), "streaming");
        end
        drainAll();

        // Exhaustive sweep of every nibble under four maskings
        creditMode = RANDOM;
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 16; i++) begin
                queueItem(4'(i), invGf4(4'(i)), "exhaustive");
            end
        end
        drainAll();

        // Involution feeds the results back in with new masks
        for (int i = 0; i < 16; i++) begin
            orig.push_back(4'(i));
            queueItem(4'(i), invGf4(4'(i)), "involution-1");
        end
        drainAll();
        while (fbQ.size() != 0 && orig.size() != 0) begin
            queueItem(fbQ.pop_front(), orig.pop_front(), "involution-2");
        end
        drainAll();

        $display("%0d items checked, %0d errors", outTotal, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
